// File: Makefile
# Verilator build and run for the RSA-256 accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_rsa_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides the outcome, not the simulator exit status
run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
src/rsa_pkg.sv
src/rsa_wb_regs.sv
src/rsa_mod_product.sv
src/rsa_mont_mult.sv
src/rsa_exp_engine.sv
src/rsa_top.sv
testbench/tb_rsa_top.sv

// File: src/rsa_exp_engine.sv
// RSA exponentiation stage
// Right-to-left square-and-multiply with one squarer and one multiplier
`timescale 1ns/1ns

module rsa_exp_engine
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  rsa_prep_t i_prep,
	input  logic      i_prep_valid,
	output logic      o_prep_ready,
	output rsa_word_t o_result,
	output logic      o_done
);

	exp_state_t state;
	rsa_prep_t  job;
	rsa_word_t  m;
	rsa_cnt_t   idx;
	logic       bit_set;
	logic       sqr_pend;
	logic       mul_pend;
	logic       sqr_start;
	logic       mul_start;
	logic       sqr_done;
	logic       mul_done;
	rsa_word_t  sqr_z;
	rsa_word_t  mul_z;

	assign bit_set = job.d[idx[7:0]];
	assign sqr_start = (state == EXP_RUN);
	assign mul_start = (state == EXP_RUN) & bit_set;

	assign o_prep_ready = (state == EXP_IDLE);
	assign o_done = (state == EXP_DONE);
	assign o_result = m;

	// m stays in the normal domain since t carries the 2^256 factor
	rsa_mont_mult u_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mul_start),
		.i_n     (job.n),
		.i_x     (m),
		.i_y     (job.t),
		.o_z     (mul_z),
		.o_done  (mul_done)
	);

	rsa_mont_mult u_sqr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (sqr_start),
		.i_n     (job.n),
		.i_x     (job.t),
		.i_y     (job.t),
		.o_z     (sqr_z),
		.o_done  (sqr_done)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= EXP_IDLE;
			idx <= '0;
			sqr_pend <= 1'b0;
			mul_pend <= 1'b0;
		end else begin
			case (state)
				EXP_IDLE: begin
					idx <= '0;
					if (i_prep_valid) begin
						state <= EXP_RUN;
					end
				end
				EXP_RUN: begin
					sqr_pend <= 1'b1;
					mul_pend <= bit_set;
					state <= EXP_WAIT;
				end
				EXP_WAIT: begin
					if (sqr_done) begin
						sqr_pend <= 1'b0;
					end
					if (mul_done) begin
						mul_pend <= 1'b0;
					end
					if (!sqr_pend && !mul_pend) begin
						state <= EXP_NEXT;
					end
				end
				EXP_NEXT: begin
					if (idx == LAST_BIT) begin
						state <= EXP_DONE;
					end else begin
						idx <= idx + 1'b1;
						state <= EXP_RUN;
					end
				end
				EXP_DONE: begin
					state <= EXP_IDLE;
				end
				default: begin
					state <= EXP_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == EXP_IDLE && i_prep_valid) begin
			job <= i_prep;
			m <= rsa_word_t'(1);
		end else if (state == EXP_WAIT) begin
			if (sqr_done) begin
				job.t <= sqr_z;
			end
			if (mul_done) begin
				m <= mul_z;
			end
		end
	end

endmodule

// File: src/rsa_mod_product.sv
// RSA preparation stage
// Brings the base into the Montgomery domain by 256 modular doublings
`timescale 1ns/1ns

module rsa_mod_product
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  rsa_job_t  i_job,
	input  logic      i_job_valid,
	output rsa_prep_t o_prep,
	output logic      o_prep_valid,
	input  logic      i_prep_ready
);

	prep_state_t state;
	rsa_cnt_t    cnt;
	rsa_word_t   term;
	rsa_wide_t   dbl;

	// Term stays below n, so one subtraction is enough
	always_comb begin
		dbl = {term, 1'b0};
		if (dbl >= {1'b0, o_prep.n}) begin
			dbl = dbl - {1'b0, o_prep.n};
		end
	end

	assign o_prep_valid = (state == PREP_HOLD);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= PREP_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				PREP_IDLE: begin
					cnt <= '0;
					if (i_job_valid) begin
						state <= PREP_CALC;
					end
				end
				PREP_CALC: begin
					cnt <= cnt + 1'b1;
					if (cnt == PREP_LAST) begin
						state <= PREP_HOLD;
					end
				end
				PREP_HOLD: begin
					if (i_prep_ready) begin
						state <= PREP_IDLE;
					end
				end
				default: begin
					state <= PREP_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == PREP_IDLE && i_job_valid) begin
			o_prep.n <= i_job.n;
			o_prep.d <= i_job.d;
			term <= i_job.a;
		end else if (state == PREP_CALC) begin
			term <= dbl[RSA_W-1:0];
			// After 256 doublings term holds a * 2^256 mod n
			if (cnt == PREP_LAST) begin
				o_prep.t <= term;
			end
		end
	end

endmodule

// File: src/rsa_mont_mult.sv
// Radix-2 Montgomery multiplier
// z = x * y * 2^-256 mod n, one bit of x per cycle
`timescale 1ns/1ns

module rsa_mont_mult
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_n,
	input  rsa_word_t i_x,
	input  rsa_word_t i_y,
	output rsa_word_t o_z,
	output logic      o_done
);

	mont_state_t        state;
	rsa_cnt_t           cnt;
	rsa_word_t          x_sh;
	rsa_wide_t          acc;
	logic [RSA_W+1:0]   sum;
	rsa_wide_t          half;
	rsa_wide_t          fixed;

	// Accumulator stays below n + y, the sum needs two extra bits
	always_comb begin
		sum = {1'b0, acc};
		if (x_sh[0]) begin
			sum = sum + {2'b00, i_y};
		end
		if (sum[0]) begin
			sum = sum + {2'b00, i_n};
		end
		half = sum[RSA_W+1:1];
	end

	always_comb begin
		if (acc >= {1'b0, i_n}) begin
			fixed = acc - {1'b0, i_n};
		end else begin
			fixed = acc;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= MONT_IDLE;
			cnt <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				MONT_IDLE: begin
					cnt <= '0;
					if (i_start) begin
						state <= MONT_CALC;
					end
				end
				MONT_CALC: begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST_BIT) begin
						state <= MONT_FIX;
					end
				end
				MONT_FIX: begin
					o_done <= 1'b1;
					state <= MONT_IDLE;
				end
				default: begin
					state <= MONT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == MONT_IDLE && i_start) begin
			x_sh <= i_x;
			acc <= '0;
		end else if (state == MONT_CALC) begin
			x_sh <= x_sh >> 1;
			acc <= half;
		end else if (state == MONT_FIX) begin
			o_z <= fixed[RSA_W-1:0];
		end
	end

endmodule

// File: src/rsa_pkg.sv
// RSA-256 accelerator shared definitions
// Widths, Wishbone register map, stage payloads and FSM encodings
package rsa_pkg;

	localparam int RSA_W = 256;
	localparam int WB_W = 32;
	localparam int WB_AW = 6;
	localparam int CNT_W = 9;

	typedef logic [RSA_W-1:0] rsa_word_t;
	typedef logic [RSA_W:0]   rsa_wide_t;
	typedef logic [CNT_W-1:0] rsa_cnt_t;
	typedef logic [WB_W-1:0]  wb_data_t;
	typedef logic [WB_AW-1:0] wb_addr_t;

	// Word addresses, operands least significant word first
	localparam wb_addr_t ADDR_N      = 6'h00;
	localparam wb_addr_t ADDR_D      = 6'h08;
	localparam wb_addr_t ADDR_A      = 6'h10;
	localparam wb_addr_t ADDR_CTRL   = 6'h18;
	localparam wb_addr_t ADDR_STATUS = 6'h19;
	localparam wb_addr_t ADDR_RES    = 6'h20;

	// Last exponent bit, also the last Montgomery step
	localparam rsa_cnt_t LAST_BIT = rsa_cnt_t'(RSA_W - 1);
	// Step where the doubled base is taken as the result
	localparam rsa_cnt_t PREP_LAST = rsa_cnt_t'(RSA_W);

	typedef struct packed {
		rsa_word_t n;
		rsa_word_t d;
		rsa_word_t a;
	} rsa_job_t;

	// t is the base times 2^256 mod n
	typedef struct packed {
		rsa_word_t n;
		rsa_word_t d;
		rsa_word_t t;
	} rsa_prep_t;

	typedef enum logic [1:0] {
		PREP_IDLE,
		PREP_CALC,
		PREP_HOLD
	} prep_state_t;

	typedef enum logic [1:0] {
		MONT_IDLE,
		MONT_CALC,
		MONT_FIX
	} mont_state_t;

	typedef enum logic [2:0] {
		EXP_IDLE,
		EXP_RUN,
		EXP_WAIT,
		EXP_NEXT,
		EXP_DONE
	} exp_state_t;

endpackage

// File: src/rsa_top.sv
// RSA-256 modular exponentiation accelerator
// Wishbone register stage, Montgomery preparation and exponentiation in a chain
`timescale 1ns/1ns

module rsa_top
	import rsa_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_wb_cyc,
	input  logic     i_wb_stb,
	input  logic     i_wb_we,
	input  wb_addr_t i_wb_adr,
	input  wb_data_t i_wb_dat,
	output wb_data_t o_wb_dat,
	output logic     o_wb_ack
);

	rsa_job_t  job;
	logic      job_valid;
	rsa_prep_t prep;
	logic      prep_valid;
	logic      prep_ready;
	rsa_word_t result;
	logic      done;

	rsa_wb_regs u_regs (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_job       (job),
		.o_job_valid (job_valid),
		.i_result    (result),
		.i_done      (done)
	);

	rsa_mod_product u_prep (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_job        (job),
		.i_job_valid  (job_valid),
		.o_prep       (prep),
		.o_prep_valid (prep_valid),
		.i_prep_ready (prep_ready)
	);

	rsa_exp_engine u_exp (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_prep       (prep),
		.i_prep_valid (prep_valid),
		.o_prep_ready (prep_ready),
		.o_result     (result),
		.o_done       (done)
	);

endmodule

// File: src/rsa_wb_regs.sv
// RSA register stage
// Wishbone classic slave with operand, control, status and result registers
`timescale 1ns/1ns

module rsa_wb_regs
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_wb_cyc,
	input  logic      i_wb_stb,
	input  logic      i_wb_we,
	input  wb_addr_t  i_wb_adr,
	input  wb_data_t  i_wb_dat,
	output wb_data_t  o_wb_dat,
	output logic      o_wb_ack,
	output rsa_job_t  o_job,
	output logic      o_job_valid,
	input  rsa_word_t i_result,
	input  logic      i_done
);

	rsa_job_t   job;
	rsa_word_t  result;
	logic       busy;
	logic       done;
	logic       start_req;
	logic       acc_en;
	logic [7:0] lsb;
	wb_data_t   rd_data;

	// New access, ack not yet given
	assign acc_en = i_wb_cyc & i_wb_stb & ~o_wb_ack;
	// Bit offset of the addressed word
	assign lsb = {i_wb_adr[2:0], 5'd0};
	assign o_job = job;

	always_comb begin
		rd_data = '0;
		case (i_wb_adr[5:3])
			ADDR_N[5:3]: begin
				rd_data = job.n[lsb +: WB_W];
			end
			ADDR_D[5:3]: begin
				rd_data = job.d[lsb +: WB_W];
			end
			ADDR_A[5:3]: begin
				rd_data = job.a[lsb +: WB_W];
			end
			ADDR_RES[5:3]: begin
				rd_data = result[lsb +: WB_W];
			end
			ADDR_CTRL[5:3]: begin
				// Control word itself reads as zero
				if (i_wb_adr == ADDR_STATUS) begin
					rd_data = {30'd0, done, busy};
				end
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (acc_en && i_wb_we) begin
			case (i_wb_adr[5:3])
				ADDR_N[5:3]: job.n[lsb +: WB_W] <= i_wb_dat;
				ADDR_D[5:3]: job.d[lsb +: WB_W] <= i_wb_dat;
				ADDR_A[5:3]: job.a[lsb +: WB_W] <= i_wb_dat;
				default: ;
			endcase
		end
		if (acc_en && !i_wb_we) begin
			o_wb_dat <= rd_data;
		end
		if (i_done) begin
			result <= i_result;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			o_wb_ack <= 1'b0;
			start_req <= 1'b0;
			o_job_valid <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			o_wb_ack <= acc_en;
			start_req <= acc_en & i_wb_we & (i_wb_adr == ADDR_CTRL) & i_wb_dat[0];
			// Start during a running job is dropped
			o_job_valid <= start_req & ~busy;
			if (start_req && !busy) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (i_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

// File: testbench/tb_rsa_top.sv
// Testbench for the RSA-256 accelerator
// Directed Wishbone tests checked against a square-and-multiply reference
`timescale 1ns/1ns

module tb_rsa_top
	import rsa_pkg::*;
();

	// Per bit one run cycle, 259 wait cycles and one next cycle, rounded up
	localparam int JOB_CYCLES = 258 + 256 * 262;
	localparam int NUM_JOBS = 9;
	// One spare job covers bus traffic and status polling
	localparam int LIMIT = (NUM_JOBS + 1) * JOB_CYCLES;

	logic     i_clk;
	logic     i_rst;
	logic     i_wb_cyc;
	logic     i_wb_stb;
	logic     i_wb_we;
	wb_addr_t i_wb_adr;
	wb_data_t i_wb_dat;
	wb_data_t o_wb_dat;
	logic     o_wb_ack;
	integer   seed = 89862;
	int       cycles = 0;

	rsa_top uut (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			report_failure($sformatf("Timeout after %0d cycles, tests did not finish", cycles));
		end
	end

	task automatic check_word(input string name, input rsa_word_t exp, input rsa_word_t act);
		if (act !== exp) begin
			report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		if (act !== exp) begin
			report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic wait_ack;
		int waits;
		waits = 1;
		@(posedge i_clk);
		#1;
		while (!o_wb_ack) begin
			if (waits >= 4) begin
				report_failure("No Wishbone ack within 4 cycles of the strobe");
			end
			waits++;
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = 1'b1;
		i_wb_adr = adr;
		i_wb_dat = dat;
		wait_ack();
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = 1'b0;
		i_wb_adr = adr;
		wait_ack();
		dat = o_wb_dat;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	task automatic rsa_load(input rsa_word_t n, input rsa_word_t d, input rsa_word_t a);
		int i;
		for (i = 0; i < 8; i++) begin
			wb_write(wb_addr_t'(ADDR_N + i), n[32*i +: 32]);
			wb_write(wb_addr_t'(ADDR_D + i), d[32*i +: 32]);
			wb_write(wb_addr_t'(ADDR_A + i), a[32*i +: 32]);
		end
	endtask

	// Busy and done update one cycle after the start write is acked
	task automatic start_job;
		wb_write(ADDR_CTRL, wb_data_t'(1));
		@(posedge i_clk);
		#1;
	endtask

	task automatic wait_done;
		wb_data_t st;
		st = '0;
		while (!st[1]) begin
			repeat (64) @(posedge i_clk);
			#1;
			wb_read(ADDR_STATUS, st);
		end
	endtask

	task automatic read_result(output rsa_word_t res);
		wb_data_t w;
		int i;
		for (i = 0; i < 8; i++) begin
			wb_read(wb_addr_t'(ADDR_RES + i), w);
			res[32*i +: 32] = w;
		end
	endtask

	task automatic rsa_start_and_wait(output rsa_word_t res);
		start_job();
		wait_done();
		read_result(res);
	endtask

	function automatic rsa_word_t rand_word();
		rsa_word_t w;
		int i;
		for (i = 0; i < 8; i++) begin
			w[32*i +: 32] = $random(seed);
		end
		return w;
	endfunction

	// Odd and full width
	function automatic rsa_word_t rand_modulus();
		rsa_word_t w;
		w = rand_word();
		w[0] = 1'b1;
		w[RSA_W-1] = 1'b1;
		return w;
	endfunction

	function automatic rsa_word_t ref_mod_exp(input rsa_word_t n, input rsa_word_t d,
			input rsa_word_t a);
		logic [511:0] r;
		logic [511:0] b;
		logic [511:0] m;
		int i;
		m = {256'd0, n};
		r = 512'd1;
		b = {256'd0, a} % m;
		for (i = 0; i < RSA_W; i++) begin
			if (d[i]) begin
				r = (r * b) % m;
			end
			b = (b * b) % m;
		end
		return r[RSA_W-1:0];
	endfunction

	task automatic test_register_readback;
		wb_data_t words [24];
		wb_data_t rd;
		int i;
		for (i = 0; i < 24; i++) begin
			words[i] = $random(seed);
			wb_write(wb_addr_t'(ADDR_N + i), words[i]);
		end
		for (i = 0; i < 24; i++) begin
			wb_read(wb_addr_t'(ADDR_N + i), rd);
			check_data($sformatf("o_wb_dat at %02h", i), words[i], rd);
		end
		wb_read(ADDR_CTRL, rd);
		check_data("o_wb_dat at ctrl", '0, rd);
		wb_read(6'h1a, rd);
		check_data("o_wb_dat at 1a", '0, rd);
		wb_read(6'h28, rd);
		check_data("o_wb_dat at 28", '0, rd);
		wb_read(6'h3f, rd);
		check_data("o_wb_dat at 3f", '0, rd);
		// Strobe held past the ack, ack still lasts one cycle
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = 1'b0;
		i_wb_adr = ADDR_N;
		wait_ack();
		@(posedge i_clk);
		#1;
		if (o_wb_ack !== 1'b0) begin
			report_failure("Wishbone ack stayed high for more than one cycle");
		end
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	task automatic test_edge_exponents;
		rsa_word_t n;
		rsa_word_t a;
		rsa_word_t res;
		n = rand_modulus();
		a = rand_word() % n;
		rsa_load(n, '0, a);
		rsa_start_and_wait(res);
		check_word("result with d=0", rsa_word_t'(1), res);
		rsa_load(n, rsa_word_t'(1), a);
		rsa_start_and_wait(res);
		check_word("result with d=1", a, res);
		rsa_load(rsa_word_t'(187), rsa_word_t'(7), rsa_word_t'(88));
		rsa_start_and_wait(res);
		check_word("result 88^7 mod 187", rsa_word_t'(11), res);
	endtask

	task automatic test_random_jobs;
		rsa_word_t n;
		rsa_word_t d;
		rsa_word_t a;
		rsa_word_t res;
		int i;
		for (i = 0; i < 4; i++) begin
			n = rand_modulus();
			d = rand_word();
			a = rand_word() % n;
			rsa_load(n, d, a);
			rsa_start_and_wait(res);
			check_word($sformatf("result of random job %0d", i), ref_mod_exp(n, d, a), res);
		end
	endtask

	task automatic test_status_protocol;
		rsa_word_t n;
		rsa_word_t d;
		rsa_word_t a;
		rsa_word_t res;
		wb_data_t st;
		n = rand_modulus();
		d = rand_word();
		a = rand_word() % n;
		rsa_load(n, d, a);
		start_job();
		wb_read(ADDR_STATUS, st);
		check_data("status after start", wb_data_t'(1), st);
		// Preparation stage hands the job on after 258 cycles and is idle again
		repeat (260) @(posedge i_clk);
		#1;
		// New base and a second start while busy must not disturb the job
		rsa_load(n, d, rand_word() % n);
		wb_write(ADDR_CTRL, wb_data_t'(1));
		wb_read(ADDR_STATUS, st);
		check_data("status after ignored start", wb_data_t'(1), st);
		wait_done();
		wb_read(ADDR_STATUS, st);
		check_data("status at end of job", wb_data_t'(2), st);
		read_result(res);
		check_word("result of first operands", ref_mod_exp(n, d, a), res);
	endtask

	task automatic test_back_to_back;
		rsa_word_t n;
		rsa_word_t d;
		rsa_word_t a;
		rsa_word_t res;
		wb_data_t st;
		n = rand_modulus();
		d = rand_word();
		a = rand_word() % n;
		rsa_load(n, d, a);
		start_job();
		wb_read(ADDR_STATUS, st);
		check_data("status at second start", wb_data_t'(1), st);
		wait_done();
		read_result(res);
		check_word("result of second job", ref_mod_exp(n, d, a), res);
	endtask

	initial begin
		i_rst = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		repeat (5) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		@(posedge i_clk);
		#1;
		test_register_readback();
		test_edge_exponents();
		test_random_jobs();
		test_status_protocol();
		test_back_to_back();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
